//--- logic/aes_defines.svh
// AES block, word and byte widths, round count and round counter width
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// block and key share one width
`define AES_BLOCK_W 128

// one state column or one key word
`define AES_WORD_W 32

`define AES_BYTE_W 8

// rounds after the initial key addition
`define AES_NUM_ROUNDS 10

// round counter holds 0 to 10
`define AES_IDX_W 4

`endif

//--- logic/aes_pkg.sv
// AES types, controller state enum and GF(2^8) byte functions
`include "aes_defines.svh"

package aes_pkg;

    // most significant byte is state byte 0
    typedef logic [`AES_BLOCK_W-1:0] block_t;
    typedef logic [`AES_WORD_W-1:0]  word_t;
    typedef logic [`AES_BYTE_W-1:0]  byte_t;
    typedef logic [`AES_IDX_W-1:0]   round_idx_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROUND,
        ST_KEY_STEP,
        ST_DONE
    } ctrl_state_e;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // shift and add product
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            acc = acc ^ (sh & {`AES_BYTE_W{b[i]}});
            sh  = xtime(sh);
        end
        return acc;
    endfunction

    // a^254 by repeated squaring, zero maps to zero
    function automatic byte_t gf_inv(input byte_t a);
        byte_t sq;
        byte_t acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < `AES_BYTE_W; i++) begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // forward S-box: field inverse then affine map
    function automatic byte_t sub_byte(input byte_t b);
        byte_t inv;
        byte_t res;
        inv = gf_inv(b);
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            res[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                   ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
        end
        return res ^ 8'h63;
    endfunction

    // 01 doubled idx times, gives 1b and 36 for the last two
    function automatic byte_t rcon(input round_idx_t idx);
        byte_t rc;
        rc = 8'h01;
        for (int i = 0; i < `AES_NUM_ROUNDS - 1; i++) begin
            if (i < int'(idx)) begin
                rc = xtime(rc);
            end
        end
        return rc;
    endfunction

endpackage

//--- logic/sbox_arbiter.sv
// fixed-priority arbiter and shared four-lane S-box word
`timescale 1ns/1ps
`include "aes_defines.svh"

module sbox_arbiter (
    input  logic           i_key_req,
    input  aes_pkg::word_t i_key_word,
    input  logic           i_round_req,
    input  aes_pkg::word_t i_round_word,
    output aes_pkg::word_t o_sub_word
);

    localparam int NUM_LANES = `AES_WORD_W / `AES_BYTE_W;
    localparam int BW = `AES_BYTE_W;

    aes_pkg::word_t sel_word;

    // key expander wins, idle lanes see zero
    always_comb begin
        if (i_key_req) begin
            sel_word = i_key_word;
        end else if (i_round_req) begin
            sel_word = i_round_word;
        end else begin
            sel_word = '0;
        end
    end

    for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
        assign o_sub_word[BW*lane +: BW] = aes_pkg::sub_byte(sel_word[BW*lane +: BW]);
    end

endmodule

//--- logic/key_expander.sv
// round key register and forward AES-128 key step
`timescale 1ns/1ps

module key_expander (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_load,
    input  aes_pkg::block_t     i_key,
    input  logic                i_step,
    input  aes_pkg::round_idx_t i_round_idx,
    output aes_pkg::block_t     o_round_key,
    output logic                o_sbox_req,
    output aes_pkg::word_t      o_sbox_word,
    input  aes_pkg::word_t      i_sbox_word
);

    aes_pkg::block_t key_q;
    aes_pkg::word_t  g_word;
    aes_pkg::word_t  w0;
    aes_pkg::word_t  w1;
    aes_pkg::word_t  w2;
    aes_pkg::word_t  w3;

    // last key word goes out for substitution
    assign o_sbox_req  = i_step;
    assign o_sbox_word = key_q[31:0];

    // rotate the substituted word left by one byte, rcon into the top byte
    assign g_word = {i_sbox_word[23:16] ^ aes_pkg::rcon(i_round_idx),
                     i_sbox_word[15:0], i_sbox_word[31:24]};

    // each new word chains on the one before
    assign w0 = key_q[127:96] ^ g_word;
    assign w1 = key_q[95:64] ^ w0;
    assign w2 = key_q[63:32] ^ w1;
    assign w3 = key_q[31:0] ^ w2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q <= '0;
        end else if (i_load) begin
            key_q <= i_key;
        end else if (i_step) begin
            key_q <= {w0, w1, w2, w3};
        end
    end

    assign o_round_key = key_q;

endmodule

//--- logic/round_datapath.sv
// AES state register and one encryption round per enabled cycle
`timescale 1ns/1ps
`include "aes_defines.svh"

module round_datapath (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_load,
    input  aes_pkg::block_t i_block,
    input  logic            i_round_en,
    input  logic            i_first,
    input  logic            i_last,
    input  aes_pkg::block_t i_round_key,
    output aes_pkg::block_t o_state,
    output logic            o_sbox_req,
    output aes_pkg::word_t  o_sbox_word,
    input  aes_pkg::word_t  i_sbox_word
);

    localparam int TOP = `AES_BLOCK_W - 1;
    localparam int BW  = `AES_BYTE_W;

    aes_pkg::block_t state_q;
    aes_pkg::block_t sub_s;
    aes_pkg::block_t shift_s;
    aes_pkg::block_t mix_s;
    aes_pkg::block_t round_out;

    // column times the fixed 02 03 01 01 circulant
    function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t col);
        aes_pkg::byte_t a [4];
        aes_pkg::byte_t total;
        aes_pkg::word_t res;
        for (int r = 0; r < 4; r++) begin
            a[r] = col[31 - 8*r -: 8];
        end
        total = a[0] ^ a[1] ^ a[2] ^ a[3];
        for (int r = 0; r < 4; r++) begin
            res[31 - 8*r -: 8] = a[r] ^ total ^ aes_pkg::xtime(a[r] ^ a[(r + 1) % 4]);
        end
        return res;
    endfunction

    // column 0 is substituted in the shared S-box word
    assign o_sbox_req  = i_round_en && !i_first;
    assign o_sbox_word = state_q[TOP -: 32];

    always_comb begin
        sub_s[TOP -: 32] = i_sbox_word;
        for (int k = 4; k < 16; k++) begin
            sub_s[TOP - BW*k -: BW] = aes_pkg::sub_byte(state_q[TOP - BW*k -: BW]);
        end
    end

    // row r moves left by r columns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_s[TOP - BW*(4*c + r) -: BW] = sub_s[TOP - BW*(4*((c + r) % 4) + r) -: BW];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mix_s[TOP - 32*c -: 32] = mix_col(shift_s[TOP - 32*c -: 32]);
        end
    end

    // final round skips the column mix
    assign round_out = (i_last ? shift_s : mix_s) ^ i_round_key;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (i_load) begin
            state_q <= i_block;
        end else if (i_round_en) begin
            // round 0 is the key addition alone
            state_q <= i_first ? (state_q ^ i_round_key) : round_out;
        end
    end

    assign o_state = state_q;

endmodule

//--- logic/aes_ctrl.sv
// round sequencing FSM, round counter and ready strobe
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_start,
    output logic                o_load,
    output logic                o_round_en,
    output logic                o_first,
    output logic                o_last,
    output logic                o_key_step,
    output aes_pkg::round_idx_t o_round_idx,
    output logic                o_ready
);

    localparam aes_pkg::round_idx_t LAST_IDX = aes_pkg::round_idx_t'(`AES_NUM_ROUNDS);

    aes_pkg::ctrl_state_e state_q;
    aes_pkg::ctrl_state_e state_d;
    aes_pkg::round_idx_t  cnt_q;
    aes_pkg::round_idx_t  cnt_d;
    logic                 ready_q;

    // round and key step alternate, start only counts in idle
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            aes_pkg::ST_IDLE: begin
                cnt_d = '0;
                if (i_start) begin
                    state_d = aes_pkg::ST_ROUND;
                end
            end
            aes_pkg::ST_ROUND: begin
                state_d = (cnt_q == LAST_IDX) ? aes_pkg::ST_DONE : aes_pkg::ST_KEY_STEP;
            end
            aes_pkg::ST_KEY_STEP: begin
                cnt_d   = cnt_q + 1'b1;
                state_d = aes_pkg::ST_ROUND;
            end
            default: begin
                state_d = aes_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= aes_pkg::ST_IDLE;
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            // one cycle pulse on the edge that leaves done
            ready_q <= (state_q == aes_pkg::ST_DONE);
        end
    end

    assign o_load      = (state_q == aes_pkg::ST_IDLE) && i_start;
    assign o_round_en  = (state_q == aes_pkg::ST_ROUND);
    assign o_key_step  = (state_q == aes_pkg::ST_KEY_STEP);
    assign o_first     = (cnt_q == '0);
    assign o_last      = (cnt_q == LAST_IDX);
    // during a key step this is the round just finished
    assign o_round_idx = cnt_q;
    assign o_ready     = ready_q;

endmodule

//--- logic/aes_core.sv
// iterative AES-128 encryption core top level
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_start,
    input  logic [`AES_BLOCK_W-1:0] i_key,
    input  logic [`AES_BLOCK_W-1:0] i_block,
    output logic [`AES_BLOCK_W-1:0] o_cipher,
    output logic                    o_ready
);

    logic                    load;
    logic                    round_en;
    logic                    first;
    logic                    last;
    logic                    key_step;
    logic [`AES_IDX_W-1:0]   round_idx;
    logic [`AES_BLOCK_W-1:0] round_key;

    // shared S-box link
    logic                    key_req;
    logic [`AES_WORD_W-1:0]  key_word;
    logic                    round_req;
    logic [`AES_WORD_W-1:0]  round_word;
    logic [`AES_WORD_W-1:0]  sub_word;

    aes_ctrl aes_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_start     (i_start),
        .o_load      (load),
        .o_round_en  (round_en),
        .o_first     (first),
        .o_last      (last),
        .o_key_step  (key_step),
        .o_round_idx (round_idx),
        .o_ready     (o_ready)
    );

    round_datapath round_datapath_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_load      (load),
        .i_block     (i_block),
        .i_round_en  (round_en),
        .i_first     (first),
        .i_last      (last),
        .i_round_key (round_key),
        .o_state     (o_cipher),
        .o_sbox_req  (round_req),
        .o_sbox_word (round_word),
        .i_sbox_word (sub_word)
    );

    key_expander key_expander_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_load      (load),
        .i_key       (i_key),
        .i_step      (key_step),
        .i_round_idx (round_idx),
        .o_round_key (round_key),
        .o_sbox_req  (key_req),
        .o_sbox_word (key_word),
        .i_sbox_word (sub_word)
    );

    sbox_arbiter sbox_arbiter_i (
        .i_key_req    (key_req),
        .i_key_word   (key_word),
        .i_round_req  (round_req),
        .i_round_word (round_word),
        .o_sub_word   (sub_word)
    );

endmodule

//--- testbench/tb_aes_core.sv
// aes_core testbench with known-answer table, ready timing checks and watchdog
`timescale 1ns/1ps

module tb_aes_core;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 4;
    localparam int NUM_ENTRIES     = 6;
    localparam int READY_EDGE      = 22;
    localparam int READY_LIMIT     = 40;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 30 + RESET_CYCLES;

    logic            clk;
    logic            rst_n;
    logic            i_start;
    aes_pkg::block_t i_key;
    aes_pkg::block_t i_block;
    aes_pkg::block_t o_cipher;
    logic            o_ready;

    // table columns are key, plaintext, ciphertext, idle cycles before start and busy noise
    aes_pkg::block_t tbl_key [NUM_ENTRIES];
    aes_pkg::block_t tbl_plain [NUM_ENTRIES];
    aes_pkg::block_t tbl_cipher [NUM_ENTRIES];
    int              tbl_gap [NUM_ENTRIES];
    bit              tbl_disturb [NUM_ENTRIES];

    logic [31:0]     lfsr_state;
    // ciphertext expected on o_cipher between blocks
    aes_pkg::block_t held_cipher;

    aes_core aes_core_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_start  (i_start),
        .i_key    (i_key),
        .i_block  (i_block),
        .o_cipher (o_cipher),
        .o_ready  (o_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_block(output aes_pkg::block_t v);
        v = '0;
        for (int i = 0; i < 128; i++) begin
            v = {v[126:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // fresh random key and block while the core is busy
    task automatic scramble_inputs();
        aes_pkg::block_t rnd;
        random_block(rnd);
        i_key <= rnd;
        random_block(rnd);
        i_block <= rnd;
    endtask

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic set_entry(input int idx, input aes_pkg::block_t key,
                             input aes_pkg::block_t plain, input aes_pkg::block_t cipher,
                             input int gap, input bit disturb);
        tbl_key[idx]     = key;
        tbl_plain[idx]   = plain;
        tbl_cipher[idx]  = cipher;
        tbl_gap[idx]     = gap;
        tbl_disturb[idx] = disturb;
    endtask

    // no ready pulse, last result still on the output
    task automatic check_idle_cycle();
        assert (o_ready == 1'b0) else begin
            stop_on_error($sformatf("Mismatch o_ready: expected 0, got %0h", o_ready));
        end
        assert (o_cipher == held_cipher) else begin
            stop_on_error($sformatf("Mismatch o_cipher: expected %032h, got %032h",
                                    held_cipher, o_cipher));
        end
    endtask

    task automatic run_entry(input int idx);
        int   edges;
        logic got;
        repeat (tbl_gap[idx]) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_cycle();
        end
        @(posedge clk);
        i_start <= 1'b1;
        i_key   <= tbl_key[idx];
        i_block <= tbl_plain[idx];
        @(negedge clk);
        check_idle_cycle();
        // this edge samples the start
        @(posedge clk);
        i_start <= 1'b0;
        if (tbl_disturb[idx]) begin
            scramble_inputs();
        end
        edges = 0;
        got   = 1'b0;
        while (!got && edges < READY_LIMIT) begin
            @(posedge clk);
            edges++;
            if (tbl_disturb[idx]) begin
                scramble_inputs();
                // a second start while busy
                i_start <= (edges >= 3 && edges < 5);
            end
            @(negedge clk);
            got = o_ready;
        end
        assert (got) else begin
            stop_on_error($sformatf("o_ready did not rise within %0d cycles of start %0d",
                                    READY_LIMIT, idx));
        end
        assert (edges == READY_EDGE) else begin
            stop_on_error($sformatf("Mismatch o_ready rise edge: expected %0h, got %0h",
                                    READY_EDGE, edges));
        end
        assert (o_cipher == tbl_cipher[idx]) else begin
            stop_on_error($sformatf("Mismatch o_cipher: expected %032h, got %032h",
                                    tbl_cipher[idx], o_cipher));
        end
        held_cipher = tbl_cipher[idx];
    endtask

    initial begin
        rst_n       = 1'b0;
        i_start     = 1'b0;
        i_key       = '0;
        i_block     = '0;
        lfsr_state  = 32'h3d92dfda;
        held_cipher = '0;
        set_entry(0, 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
                  128'h3243f6a8_885a308d_313198a2_e0370734,
                  128'h3925841d_02dc09fb_dc118597_196a0b32, 2, 1'b0);
        set_entry(1, 128'h00010203_04050607_08090a0b_0c0d0e0f,
                  128'h00112233_44556677_8899aabb_ccddeeff,
                  128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a, 0, 1'b0);
        set_entry(2, '0, '0, 128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e, 0, 1'b0);
        set_entry(3, tbl_key[0], tbl_plain[0], tbl_cipher[0], 3, 1'b1);
        set_entry(4, tbl_key[1], tbl_plain[1], tbl_cipher[1], 0, 1'b1);
        set_entry(5, '0, '0, tbl_cipher[2], 1, 1'b0);
        // reset spans four rising edges
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            check_idle_cycle();
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        @(posedge clk);
        @(negedge clk);
        check_idle_cycle();
        $display("TEST PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error("watchdog expired before all table entries completed");
    end

endmodule

//--- project.f
+incdir+logic
logic/aes_pkg.sv
logic/sbox_arbiter.sv
logic/key_expander.sv
logic/round_datapath.sv
logic/aes_ctrl.sv
logic/aes_core.sv
testbench/tb_aes_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_aes_core
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
